//--- project.f
source/mac_glue_pkg.sv
source/reset_sequencer.sv
source/download_control.sv
source/floppy_status.sv
source/sdram_port_mux.sv
source/mac_glue_top.sv
tests/tb_mac_glue.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the glue testbench with Verilator, fail if the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -f project.f \
	--top-module tb_mac_glue -Mdir obj_dir \
	&& ./obj_dir/Vtb_mac_glue > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

//--- source/download_control.sv
// Host download staging that byte swaps words, maps addresses and paces writes with the bus slot
`timescale 1ns/1ps

module download_control (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic                     dl_active,
	input  mac_glue_pkg::dl_index_t   dl_index,
	input  logic                     ioctl_wr,
	input  mac_glue_pkg::ioctl_addr_t ioctl_addr,
	input  mac_glue_pkg::word_t       ioctl_data,
	input  logic                     dio_slot,
	output logic                     ioctl_wait,
	output mac_glue_pkg::dio_addr_t   dio_a,
	output mac_glue_pkg::word_t       dio_data,
	output logic                     dio_write,
	output logic                     download_cycle,
	output logic                     dl_done,
	output mac_glue_pkg::img_words_t  dl_words
);

	mac_glue_pkg::dl_state_t  dl_state;
	// Slot and download flags from the previous cycle
	logic                    slot_d;
	logic                    dl_active_d;
	// Host byte address as a word address
	mac_glue_pkg::img_words_t word_addr;

	assign word_addr = ioctl_addr[24:1];

	// ==============================
	// Handshake FSM
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dl_state    <= mac_glue_pkg::DL_IDLE;
			slot_d      <= 1'b0;
			dl_active_d <= 1'b0;
		end else begin
			slot_d      <= dio_slot;
			dl_active_d <= dl_active;
			case (dl_state)
				// Word accepted from the host
				mac_glue_pkg::DL_IDLE:
					if (ioctl_wr) dl_state <= mac_glue_pkg::DL_PENDING;
				// Arm only outside the slot so a whole slot sees the write
				mac_glue_pkg::DL_PENDING:
					if (!dio_slot) dl_state <= mac_glue_pkg::DL_ARMED;
				// Falling slot edge means the SDRAM took the word
				mac_glue_pkg::DL_ARMED:
					if (slot_d && !dio_slot) dl_state <= mac_glue_pkg::DL_IDLE;
				default:
					dl_state <= mac_glue_pkg::DL_IDLE;
			endcase
		end
	end

	// Host is held off until the staged word is written
	assign ioctl_wait = (dl_state != mac_glue_pkg::DL_IDLE);
	assign dio_write  = (dl_state == mac_glue_pkg::DL_ARMED);

	// ==============================
	// Word staging
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr && dl_state == mac_glue_pkg::DL_IDLE) begin
			// Host sends bytes in the opposite order to the 68000
			dio_data <= {ioctl_data[7:0], ioctl_data[15:8]};
			// Floppy images go behind the ROM at word offsets 0x80000 and 0x100000
			if (dl_index[1:0] != 2'b00)
				dio_a <= {dl_index[1:0], word_addr[18:0]};
			else
				dio_a <= {2'b00, dl_index[6], word_addr[17:0]};
		end
		// Host leaves the address one past the final word, so this ends as the length
		if (dl_active)
			dl_words <= word_addr;
	end

	assign download_cycle = dl_active & dio_slot;
	// One cycle pulse at the end of a download
	assign dl_done        = dl_active_d & ~dl_active;

endmodule

//--- source/floppy_status.sv
// Floppy image recognition by download length with eject, plus the disk activity LED stretcher
`timescale 1ns/1ps

module floppy_status #(
	parameter int ACT_HOLD = 64
) (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    dl_done,
	input  mac_glue_pkg::dl_index_t  dl_index,
	input  mac_glue_pkg::img_words_t dl_words,
	input  logic [1:0]              disk_eject,
	input  logic [1:0]              disk_act_pulse,
	input  logic [1:0]              disk_motor,
	input  logic                    dl_active,
	output logic [1:0]              disk_inserted,
	output logic [1:0]              disk_double_sided,
	output logic                    led_user
);

	localparam int ACT_W = $clog2(ACT_HOLD + 1);

	// Remaining activity cycles
	logic [ACT_W-1:0] act_timer;
	logic             disk_act;

	// ==============================
	// Per drive image flags
	// ==============================

	// Drive 0 loads from index 1, drive 1 from index 2
	for (genvar d = 0; d < 2; d++) begin : g_drive
		logic img_ds;
		logic img_ss;

		always_ff @(posedge clk_sys) begin
			if (rst) begin
				img_ds <= 1'b0;
				img_ss <= 1'b0;
			end else if (disk_eject[d]) begin
				// Ejected by the OS
				img_ds <= 1'b0;
				img_ss <= 1'b0;
			end else if (dl_done && dl_index == mac_glue_pkg::dl_index_t'(d + 1)) begin
				// Unknown sizes leave the drive empty
				img_ds <= (dl_words == mac_glue_pkg::IMG_WORDS_DS);
				img_ss <= (dl_words == mac_glue_pkg::IMG_WORDS_SS);
			end
		end

		assign disk_double_sided[d] = img_ds;
		assign disk_inserted[d]     = img_ds | img_ss;
	end

	// ==============================
	// Activity LED
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst)
			act_timer <= '0;
		else if (|disk_act_pulse)
			act_timer <= ACT_W'(ACT_HOLD);
		else if (act_timer != '0)
			act_timer <= act_timer - 1'b1;
	end

	assign disk_act = (act_timer != '0);
	// LED blinks against the motor state, solid during a download
	assign led_user = dl_active | (disk_act ^ (|disk_motor));

endmodule

//--- source/mac_glue_pkg.sv
// Shared widths, download states and memory map constants for the Mac Plus system glue RTL
package mac_glue_pkg;

	// ==============================
	// Data and address widths
	// ==============================

	// One SDRAM or host data word
	typedef logic [15:0] word_t;
	// SDRAM word address
	typedef logic [24:0] sdram_addr_t;
	// Chipset memory byte address
	typedef logic [21:0] mem_addr_t;
	// Host download byte address
	typedef logic [24:0] ioctl_addr_t;
	// Staged word address inside the ROM and disk region
	typedef logic [20:0] dio_addr_t;
	// Download length in words
	typedef logic [23:0] img_words_t;
	// Download target where 0 is ROM, 1 the internal and 2 the external floppy
	typedef logic [7:0] dl_index_t;

	// Download handshake states
	typedef enum logic [1:0] {
		DL_IDLE    = 2'd0,
		DL_PENDING = 2'd1,
		DL_ARMED   = 2'd2
	} dl_state_t;

	// ==============================
	// Memory map and image sizes
	// ==============================

	// 800K double sided floppy in words
	localparam img_words_t IMG_WORDS_DS = 24'd409600;
	// 400K single sided floppy in words
	localparam img_words_t IMG_WORDS_SS = 24'd204800;
	// ROM and download data live above RAM
	localparam logic [3:0] ROM_REGION_TAG = 4'b0001;

endpackage

//--- source/mac_glue_top.sv
// Top level of the Mac Plus system glue, wiring reset, download, floppy and SDRAM port blocks
`timescale 1ns/1ps

module mac_glue_top #(
	parameter int RESET_HOLD = 16,
	parameter int ACT_HOLD   = 64
) (
	input  logic                     clk_sys,
	input  logic                     rst,
	// Reset requests and machine selections
	input  logic                     user_reset,
	input  logic                     cpu_reset_req,
	input  logic                     sel_mem_4mb,
	input  logic                     sel_model_se,
	output logic                     sys_reset_n,
	output logic                     cfg_mem_4mb,
	output logic                     cfg_model_se,
	// Host download
	input  logic                     dl_active,
	input  mac_glue_pkg::dl_index_t   dl_index,
	input  logic                     ioctl_wr,
	input  mac_glue_pkg::ioctl_addr_t ioctl_addr,
	input  mac_glue_pkg::word_t       ioctl_data,
	output logic                     ioctl_wait,
	input  logic                     dio_slot,
	// Floppy drives
	input  logic [1:0]               disk_eject,
	input  logic [1:0]               disk_act_pulse,
	input  logic [1:0]               disk_motor,
	output logic [1:0]               disk_inserted,
	output logic [1:0]               disk_double_sided,
	output logic                     led_user,
	// Chipset memory side
	input  mac_glue_pkg::mem_addr_t   mem_addr,
	input  mac_glue_pkg::word_t       mem_wdata,
	input  logic                     uds_n,
	input  logic                     lds_n,
	input  logic                     rom_oe_n,
	input  logic                     ram_oe_n,
	input  logic                     ram_we_n,
	input  logic                     disk_ack,
	output mac_glue_pkg::word_t       cpu_rdata,
	// SDRAM controller side
	input  mac_glue_pkg::word_t       sdram_rdata,
	output mac_glue_pkg::sdram_addr_t sdram_addr,
	output mac_glue_pkg::word_t       sdram_din,
	output logic [1:0]               sdram_ds,
	output logic                     sdram_we,
	output logic                     sdram_oe
);

	// Staged download word
	mac_glue_pkg::dio_addr_t  dio_a;
	mac_glue_pkg::word_t      dio_data;
	logic                    dio_write;
	logic                    download_cycle;
	// End of download and its length
	logic                    dl_done;
	mac_glue_pkg::img_words_t dl_words;

	reset_sequencer #(.RESET_HOLD(RESET_HOLD)) u_reset_sequencer (
		.clk_sys(clk_sys), .rst(rst), .user_reset(user_reset), .cpu_reset_req(cpu_reset_req),
		.sel_mem_4mb(sel_mem_4mb), .sel_model_se(sel_model_se), .sys_reset_n(sys_reset_n),
		.cfg_mem_4mb(cfg_mem_4mb), .cfg_model_se(cfg_model_se)
	);

	download_control u_download_control (
		.clk_sys(clk_sys), .rst(rst), .dl_active(dl_active), .dl_index(dl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.dio_slot(dio_slot), .ioctl_wait(ioctl_wait), .dio_a(dio_a), .dio_data(dio_data),
		.dio_write(dio_write), .download_cycle(download_cycle), .dl_done(dl_done),
		.dl_words(dl_words)
	);

	floppy_status #(.ACT_HOLD(ACT_HOLD)) u_floppy_status (
		.clk_sys(clk_sys), .rst(rst), .dl_done(dl_done), .dl_index(dl_index),
		.dl_words(dl_words), .disk_eject(disk_eject), .disk_act_pulse(disk_act_pulse),
		.disk_motor(disk_motor), .dl_active(dl_active), .disk_inserted(disk_inserted),
		.disk_double_sided(disk_double_sided), .led_user(led_user)
	);

	sdram_port_mux u_sdram_port_mux (
		.download_cycle(download_cycle), .dio_a(dio_a), .dio_data(dio_data),
		.dio_write(dio_write), .cfg_model_se(cfg_model_se), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .uds_n(uds_n), .lds_n(lds_n), .rom_oe_n(rom_oe_n),
		.ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n), .disk_ack(disk_ack),
		.sdram_rdata(sdram_rdata), .sdram_addr(sdram_addr), .sdram_din(sdram_din),
		.sdram_ds(sdram_ds), .sdram_we(sdram_we), .sdram_oe(sdram_oe), .cpu_rdata(cpu_rdata)
	);

endmodule

//--- source/reset_sequencer.sv
// Reset sequencer that merges reset requests, stretches system reset and latches the configuration
`timescale 1ns/1ps

module reset_sequencer #(
	parameter int RESET_HOLD = 16
) (
	input  logic clk_sys,
	input  logic rst,
	input  logic user_reset,
	input  logic cpu_reset_req,
	input  logic sel_mem_4mb,
	input  logic sel_model_se,
	output logic sys_reset_n,
	output logic cfg_mem_4mb,
	output logic cfg_model_se
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	// Cycles left before the system leaves reset
	logic [CNT_W-1:0] hold_cnt;
	// Any source asking for a reset
	logic             reset_req;

	assign reset_req = rst | user_reset | cpu_reset_req;

	always_ff @(posedge clk_sys) begin
		if (reset_req) begin
			// Restart the hold period on every request cycle
			hold_cnt    <= CNT_W'(RESET_HOLD);
			sys_reset_n <= 1'b0;
		end else if (hold_cnt != '0) begin
			hold_cnt     <= hold_cnt - 1'b1;
			// Selections only take effect across a reset
			cfg_mem_4mb  <= sel_mem_4mb;
			cfg_model_se <= sel_model_se;
		end else begin
			// Hold period over
			sys_reset_n <= 1'b1;
		end
	end

endmodule

//--- source/sdram_port_mux.sv
// Combinational SDRAM port select between download, ROM, RAM and disk reads with read data shaping
`timescale 1ns/1ps

module sdram_port_mux (
	input  logic                     download_cycle,
	input  mac_glue_pkg::dio_addr_t   dio_a,
	input  mac_glue_pkg::word_t       dio_data,
	input  logic                     dio_write,
	input  logic                     cfg_model_se,
	input  mac_glue_pkg::mem_addr_t   mem_addr,
	input  mac_glue_pkg::word_t       mem_wdata,
	input  logic                     uds_n,
	input  logic                     lds_n,
	input  logic                     rom_oe_n,
	input  logic                     ram_oe_n,
	input  logic                     ram_we_n,
	input  logic                     disk_ack,
	input  mac_glue_pkg::word_t       sdram_rdata,
	output mac_glue_pkg::sdram_addr_t sdram_addr,
	output mac_glue_pkg::word_t       sdram_din,
	output logic [1:0]               sdram_ds,
	output logic                     sdram_we,
	output logic                     sdram_oe,
	output mac_glue_pkg::word_t       cpu_rdata
);

	// Disk image bytes replicated into both halves
	mac_glue_pkg::word_t disk_byte;

	assign disk_byte = mem_addr[0] ? {sdram_rdata[7:0], sdram_rdata[7:0]}
	                               : {sdram_rdata[15:8], sdram_rdata[15:8]};

	// ==============================
	// Port select
	// ==============================

	always_comb begin
		if (download_cycle) begin
			// Whole words from the host
			sdram_addr = {mac_glue_pkg::ROM_REGION_TAG, dio_a};
			sdram_din  = dio_data;
			sdram_ds   = 2'b11;
			sdram_we   = dio_write;
			sdram_oe   = 1'b0;
			// Reads all ones so the screen stays dark
			cpu_rdata  = 16'hffff;
		end else begin
			if (!rom_oe_n)
				// Plus and SE ROMs sit side by side
				sdram_addr = {mac_glue_pkg::ROM_REGION_TAG, 2'b00, cfg_model_se,
				              mem_addr[18:1]};
			else
				// disk_ack selects the disk image window
				sdram_addr = {3'b000, disk_ack, mem_addr[21:1]};
			sdram_din = mem_wdata;
			sdram_ds  = {~uds_n, ~lds_n};
			sdram_we  = ~ram_we_n;
			sdram_oe  = ~ram_oe_n | ~rom_oe_n | disk_ack;
			// Disk reads are byte wide
			if (disk_ack)
				cpu_rdata = disk_byte;
			else
				cpu_rdata = sdram_rdata;
		end
	end

endmodule

//--- tests/tb_mac_glue.sv
// Self-checking testbench for the Mac Plus glue, seeded random stimulus against a behavioral model
`timescale 1ns/1ps

module tb_mac_glue;

	localparam int RESET_HOLD = 16;
	localparam int ACT_HOLD   = 64;
	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS  = 5;
	// Cycle budget per test for the watchdog
	localparam int TEST_CYCLES = 2000;

	logic clk_sys, rst;
	logic user_reset, cpu_reset_req, sel_mem_4mb, sel_model_se;
	logic sys_reset_n, cfg_mem_4mb, cfg_model_se;
	logic dl_active, ioctl_wr, ioctl_wait, dio_slot;
	mac_glue_pkg::dl_index_t   dl_index;
	mac_glue_pkg::ioctl_addr_t ioctl_addr;
	mac_glue_pkg::word_t       ioctl_data, mem_wdata, cpu_rdata, sdram_rdata, sdram_din;
	logic [1:0] disk_eject, disk_act_pulse, disk_motor, disk_inserted, disk_double_sided;
	logic [1:0] sdram_ds;
	logic led_user, uds_n, lds_n, rom_oe_n, ram_oe_n, ram_we_n, disk_ack, sdram_we, sdram_oe;
	mac_glue_pkg::mem_addr_t   mem_addr;
	mac_glue_pkg::sdram_addr_t sdram_addr;

	integer      seed;
	logic [31:0] r;
	int          errors;
	int          checks;
	// Model state for the latched configuration and per drive image flags
	logic        exp_mem_4mb, exp_model_se;
	logic [1:0]  exp_ds, exp_ss;

	mac_glue_top #(.RESET_HOLD(RESET_HOLD), .ACT_HOLD(ACT_HOLD)) UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Watchdog sized from the number of tests
	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("Failure: watchdog expired at %0t, a test did not finish", $time);
		$display("Test failed");
		$finish;
	end

	// ==============================
	// Helpers and compare tasks
	// ==============================

	task automatic draw_random();
		r = $random(seed);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input mac_glue_pkg::word_t got,
	                          input mac_glue_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input mac_glue_pkg::sdram_addr_t got,
	                          input mac_glue_pkg::sdram_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_start);
		$display("test %0d %s done, %0d errors", num, name, errors - err_start);
	endtask

	// Counts cycles from the last request cycle to the release of system reset
	task automatic measure_release();
		int cyc;
		cyc = 0;
		while (!sys_reset_n && cyc < 4 * RESET_HOLD) begin
			@(negedge clk_sys);
			cyc++;
		end
		checks++;
		if (cyc != RESET_HOLD + 1) begin
			errors++;
			$display("Failure at %0t: reset released after %0d cycles, not %0d", $time, cyc,
			         RESET_HOLD + 1);
		end
		check_bit("cfg_mem_4mb", cfg_mem_4mb, exp_mem_4mb);
		check_bit("cfg_model_se", cfg_model_se, exp_model_se);
	endtask

	// Model of image recognition at the end of a download
	task automatic apply_done(input int idx, input mac_glue_pkg::img_words_t len);
		if (idx == 1 || idx == 2) begin
			exp_ds[idx-1] = (len == mac_glue_pkg::IMG_WORDS_DS);
			exp_ss[idx-1] = (len == mac_glue_pkg::IMG_WORDS_SS);
		end
	endtask

	task automatic check_flags();
		for (int d = 0; d < 2; d++) begin
			check_bit($sformatf("disk_inserted[%0d]", d), disk_inserted[d], exp_ds[d] | exp_ss[d]);
			check_bit($sformatf("disk_double_sided[%0d]", d), disk_double_sided[d], exp_ds[d]);
		end
	endtask

	// One host word, then random slots until the wait flag drops
	task automatic send_word(input int idx);
		mac_glue_pkg::sdram_addr_t exp_addr;
		mac_glue_pkg::word_t       exp_data;
		int                        cyc;
		int                        runs;
		logic                      prev;
		draw_random();
		ioctl_addr = {r[24:1], 1'b0};
		draw_random();
		ioctl_data = r[15:0];
		dio_slot   = r[16];
		ioctl_wr   = 1'b1;
		// ROM words sit low, floppy words behind the drive index
		if (idx == 0)
			exp_addr = {mac_glue_pkg::ROM_REGION_TAG, 3'b000, ioctl_addr[18:1]};
		else
			exp_addr = {mac_glue_pkg::ROM_REGION_TAG, dl_index[1:0], ioctl_addr[19:1]};
		exp_data = {ioctl_data[7:0], ioctl_data[15:8]};
		@(negedge clk_sys);
		check_bit("ioctl_wait", ioctl_wait, 1'b1);
		ioctl_wr = 1'b0;
		draw_random();
		dio_slot = r[0];
		cyc  = 0;
		runs = 0;
		prev = 1'b0;
		while (ioctl_wait && cyc < 200) begin
			@(negedge clk_sys);
			if (sdram_we) begin
				check_addr("sdram_addr", sdram_addr, exp_addr);
				check_word("sdram_din", sdram_din, exp_data);
				check_word("cpu_rdata", cpu_rdata, 16'hffff);
				check_bit("sdram_oe", sdram_oe, 1'b0);
				check_bit("sdram_ds[1]", sdram_ds[1], 1'b1);
				check_bit("sdram_ds[0]", sdram_ds[0], 1'b1);
				if (!prev)
					runs++;
			end
			prev = sdram_we;
			cyc++;
			draw_random();
			dio_slot = r[0];
		end
		checks++;
		if (ioctl_wait) begin
			errors++;
			$display("Failure at %0t: ioctl_wait stayed high for 200 cycles", $time);
		end else if (runs != 1) begin
			errors++;
			$display("Failure at %0t: download word written %0d times", $time, runs);
		end
	endtask

	// Multiplexer rule for one CPU side vector
	task automatic check_mux();
		mac_glue_pkg::sdram_addr_t exp_addr;
		mac_glue_pkg::word_t       exp_rd;
		logic [7:0]                rd_byte;
		if (dl_active && dio_slot) begin
			check_word("cpu_rdata", cpu_rdata, 16'hffff);
			check_bit("sdram_oe", sdram_oe, 1'b0);
			check_bit("sdram_we", sdram_we, 1'b0);
			check_bit("sdram_ds[1]", sdram_ds[1], 1'b1);
			check_bit("sdram_ds[0]", sdram_ds[0], 1'b1);
		end else begin
			if (!rom_oe_n)
				exp_addr = {mac_glue_pkg::ROM_REGION_TAG, 2'b00, exp_model_se, mem_addr[18:1]};
			else
				exp_addr = {3'b000, disk_ack, mem_addr[21:1]};
			// Disk reads repeat the addressed byte in both halves
			rd_byte = mem_addr[0] ? sdram_rdata[7:0] : sdram_rdata[15:8];
			if (disk_ack)
				exp_rd = {2{rd_byte}};
			else
				exp_rd = sdram_rdata;
			check_addr("sdram_addr", sdram_addr, exp_addr);
			check_word("sdram_din", sdram_din, mem_wdata);
			check_word("cpu_rdata", cpu_rdata, exp_rd);
			check_bit("sdram_ds[1]", sdram_ds[1], ~uds_n);
			check_bit("sdram_ds[0]", sdram_ds[0], ~lds_n);
			check_bit("sdram_we", sdram_we, ~ram_we_n);
			check_bit("sdram_oe", sdram_oe, !(ram_oe_n & rom_oe_n) | disk_ack);
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin : main
		int                       err0;
		int                       idx;
		mac_glue_pkg::img_words_t len;
		seed = 32'hf1cc_3880;
		errors = 0;
		checks = 0;
		rst = 1'b1;
		{user_reset, cpu_reset_req, sel_mem_4mb, sel_model_se} = 4'b0000;
		{dl_active, ioctl_wr, dio_slot} = 3'b000;
		dl_index   = '0;
		ioctl_addr = '0;
		ioctl_data = '0;
		{disk_eject, disk_act_pulse, disk_motor} = 6'b000000;
		{uds_n, lds_n, rom_oe_n, ram_oe_n, ram_we_n, disk_ack} = 6'b111110;
		mem_addr    = '0;
		mem_wdata   = '0;
		sdram_rdata = '0;
		{exp_mem_4mb, exp_model_se} = 2'b00;
		exp_ds = 2'b00;
		exp_ss = 2'b00;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;

		// Test 1 checks the power-on release and random reset requests
		err0 = errors;
		measure_release();
		repeat (8) begin
			draw_random();
			@(negedge clk_sys);
			user_reset    = r[0];
			cpu_reset_req = ~r[0] | r[1];
			sel_mem_4mb   = r[2];
			sel_model_se  = r[3];
			exp_mem_4mb   = r[2];
			exp_model_se  = r[3];
			repeat (1 + r[5:4]) @(negedge clk_sys);
			user_reset    = 1'b0;
			cpu_reset_req = 1'b0;
			measure_release();
			// New selections outside reset must leave the configuration alone
			sel_mem_4mb  = ~exp_mem_4mb;
			sel_model_se = ~exp_model_se;
			repeat (1 + r[9:6]) @(negedge clk_sys);
			check_bit("cfg_mem_4mb", cfg_mem_4mb, exp_mem_4mb);
			check_bit("cfg_model_se", cfg_model_se, exp_model_se);
		end
		report_test(1, "reset sequencer", err0);

		// Test 2 sends download words under a random slot pattern
		err0 = errors;
		@(negedge clk_sys);
		draw_random();
		idx       = int'(r % 3);
		dl_index  = mac_glue_pkg::dl_index_t'(idx);
		dl_active = 1'b1;
		repeat (24) send_word(idx);
		dl_active = 1'b0;
		dio_slot  = 1'b0;
		apply_done(idx, ioctl_addr[24:1]);
		@(negedge clk_sys);
		check_flags();
		report_test(2, "download path", err0);

		// Test 3 covers image sizes and eject
		err0 = errors;
		repeat (8) begin
			draw_random();
			idx = 1 + int'(r[0]);
			case (r[2:1])
				2'd0:    len = mac_glue_pkg::IMG_WORDS_DS;
				2'd1:    len = mac_glue_pkg::IMG_WORDS_SS;
				default: len = r[31:8];
			endcase
			@(negedge clk_sys);
			dl_active  = 1'b1;
			dl_index   = mac_glue_pkg::dl_index_t'(idx);
			ioctl_addr = {len, 1'b0};
			@(negedge clk_sys);
			check_bit("led_user", led_user, 1'b1);
			dl_active = 1'b0;
			@(negedge clk_sys);
			apply_done(idx, len);
			check_flags();
			if (r[3]) begin
				disk_eject = r[4] ? 2'b10 : 2'b01;
				exp_ds = exp_ds & ~disk_eject;
				exp_ss = exp_ss & ~disk_eject;
				@(negedge clk_sys);
				check_flags();
				disk_eject = 2'b00;
			end
		end
		report_test(3, "floppy flags", err0);

		// Test 4 drives CPU side accesses with the odd download cycle
		err0 = errors;
		dl_index = '0;
		repeat (200) begin
			draw_random();
			mem_addr  = r[21:0];
			{uds_n, lds_n, rom_oe_n, ram_oe_n, ram_we_n, disk_ack} = r[27:22];
			dl_active = (r[31:29] == 3'd0);
			dio_slot  = dl_active;
			draw_random();
			mem_wdata   = r[15:0];
			sdram_rdata = r[31:16];
			@(negedge clk_sys);
			check_mux();
		end
		{dl_active, dio_slot} = 2'b00;
		{uds_n, lds_n, rom_oe_n, ram_oe_n, ram_we_n, disk_ack} = 6'b111110;
		report_test(4, "sdram port mux", err0);

		// Test 5 stretches the activity LED with motors off
		err0 = errors;
		@(negedge clk_sys);
		check_bit("led_user", led_user, 1'b0);
		draw_random();
		disk_act_pulse = r[0] ? 2'b01 : 2'b10;
		@(negedge clk_sys);
		disk_act_pulse = 2'b00;
		repeat (ACT_HOLD / 2 - 1) @(negedge clk_sys);
		check_bit("led_user", led_user, 1'b1);
		repeat (ACT_HOLD / 2 + 2) @(negedge clk_sys);
		check_bit("led_user", led_user, 1'b0);
		report_test(5, "activity led", err0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
